// File: compile.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/isqrt_unit.sv
verilog/alu_core.sv
verilog/error_status_regs.sv
verilog/alu_subsystem.sv
sim/tb_alu_subsystem.sv

// File: run.sh
#!/bin/sh
# Build and run the ALU subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 -f compile.f --top-module tb_alu_subsystem \
  -o tb_alu_subsystem > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_alu_subsystem > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Failures found in sim.log"; exit 1; }
exit 0

// File: sim/tb_alu_subsystem.sv
// ALU subsystem testbench
`timescale 1ns/1ps
`include "alu_config.svh"

module tb_alu_subsystem import alu_pkg::*; ();

  localparam int NUM_ROWS    = 13;
  localparam int NUM_RANDOM  = 200;
  localparam int NUM_SAT     = 260;   // Enough errors to pin the counter at 255
  localparam int CYCLE_LIMIT = 2 * (NUM_ROWS + NUM_RANDOM) + 2 * NUM_SAT + 200;

  typedef struct packed {
    logic [2:0] op;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] exp_result;
    logic [3:0] exp_error;
  } row_t;

  logic        clk;
  logic        reset_n;
  logic        issue;
  operation_t  operation;
  logic [7:0]  data_a;
  logic [7:0]  data_b;
  logic [7:0]  result;
  error_code_t error_code;
  logic        result_valid;
  logic        reg_write;
  logic [1:0]  reg_addr;
  logic [7:0]  reg_wdata;
  logic [7:0]  reg_rdata;

  row_t        corner_rows [NUM_ROWS];
  integer      seed;
  int          errors;
  int          checks;
  int          tests;
  int          test_start_errors;
  int          cycle_count = 0;
  logic [7:0]  model_flags;           // Expected ERR_FLAGS contents
  int          model_count;           // Expected ERR_COUNT contents

  alu_subsystem dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .issue        (issue),
    .operation    (operation),
    .data_a       (data_a),
    .data_b       (data_b),
    .result       (result),
    .error_code   (error_code),
    .result_valid (result_valid),
    .reg_write    (reg_write),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Expected {error, result} from the operation rules
  function automatic logic [11:0] expected_outcome(input logic [2:0] op, input logic [7:0] a,
      input logic [7:0] b, input logic [5:0] mask, input logic [7:0] limit);
    int         wide;
    int         root;
    logic [3:0] err;
    logic [7:0] res;
    err = ERR_NONE;
    res = 8'd0;
    if (op > 3'd5) begin
      err = ERR_INVALID_OP;
    end else if (!mask[op]) begin
      err = ERR_INVALID_OP;
    end else begin
      case (op)
        3'd0: begin
          wide = int'(a) + int'(b);
          if (wide > 255) begin
            res = 8'd255;
            err = ERR_OVERFLOW;
          end else begin
            res = wide[7:0];
          end
        end
        3'd1: begin
          wide = int'(a) - int'(b);
          if (wide < 0) err = ERR_UNDERFLOW;
          else res = wide[7:0];
        end
        3'd2: begin
          wide = int'(a) * int'(b);
          if (wide > 255) begin
            res = 8'd255;
            err = ERR_OVERFLOW;
          end else begin
            res = wide[7:0];
          end
        end
        3'd3: begin
          if (b == 8'd0) err = ERR_DIVIDE_ZERO;
          else res = a / b;
        end
        3'd4: begin
          if (b == 8'd0) err = ERR_DIVIDE_ZERO;
          else res = a % b;
        end
        default: begin
          if (a > limit) begin
            err = ERR_OUT_OF_RANGE;
          end else begin
            root = 0;
            for (int r = 1; r < 16; r++) begin
              if (r * r <= int'(a)) root = r;   // Largest root whose square fits
            end
            res = root[7:0];
          end
        end
      endcase
    end
    return {err, res};
  endfunction

  task automatic load_corner_rows();
    corner_rows[0]  = '{OP_ADD,  8'd200, 8'd100, 8'd255, ERR_OVERFLOW};
    corner_rows[1]  = '{OP_ADD,  8'd20,  8'd30,  8'd50,  ERR_NONE};
    corner_rows[2]  = '{OP_SUB,  8'd3,   8'd5,   8'd0,   ERR_UNDERFLOW};
    corner_rows[3]  = '{OP_SUB,  8'd7,   8'd3,   8'd4,   ERR_NONE};
    corner_rows[4]  = '{OP_MUL,  8'd16,  8'd16,  8'd255, ERR_OVERFLOW};
    corner_rows[5]  = '{OP_MUL,  8'd15,  8'd17,  8'd255, ERR_NONE};
    corner_rows[6]  = '{OP_DIV,  8'd9,   8'd0,   8'd0,   ERR_DIVIDE_ZERO};
    corner_rows[7]  = '{OP_DIV,  8'd9,   8'd4,   8'd2,   ERR_NONE};
    corner_rows[8]  = '{OP_MOD,  8'd9,   8'd4,   8'd1,   ERR_NONE};
    corner_rows[9]  = '{OP_SQRT, 8'd200, 8'd0,   8'd14,  ERR_NONE};
    corner_rows[10] = '{OP_SQRT, 8'd230, 8'd0,   8'd0,   ERR_OUT_OF_RANGE};
    corner_rows[11] = '{3'd6,    8'd1,   8'd2,   8'd0,   ERR_INVALID_OP};
    corner_rows[12] = '{OP_MOD,  8'd5,   8'd0,   8'd0,   ERR_DIVIDE_ZERO};
  endtask

  task automatic start_test();
    tests++;
    test_start_errors = errors;
  endtask

  task automatic report_test(input string name);
    if (errors == test_start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
  endtask

  // Issue one operation and check it one cycle later
  task automatic run_op(input logic [2:0] op, input logic [7:0] a, input logic [7:0] b,
      input logic [7:0] exp_result, input logic [3:0] exp_error);
    @(negedge clk);
    issue     = 1'b1;
    operation = operation_t'(op);
    data_a    = a;
    data_b    = b;
    @(negedge clk);
    issue = 1'b0;
    checks++;
    if (result_valid !== 1'b1) begin
      errors++;
      $display("error at %0t: no result_valid after issue of op %0d", $time, op);
    end
    if (result !== exp_result || error_code !== exp_error) begin
      errors++;
      $display("error at %0t: op %0d a %0d b %0d gave %0d code %0d, expected %0d code %0d",
               $time, op, a, b, result, error_code, exp_result, exp_error);
    end
    if (exp_error != 4'd0) begin
      model_flags = model_flags | (8'd1 << exp_error);
      if (model_count < 255) model_count++;
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
    @(negedge clk);
    reg_write = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_write = 1'b0;
  endtask

  task automatic check_reg(input logic [1:0] addr, input logic [7:0] expected,
      input string name);
    @(negedge clk);
    reg_addr = addr;
    #1;                                 // Read path is combinational
    checks++;
    if (reg_rdata !== expected) begin
      errors++;
      $display("error at %0t: register %s reads %0h, expected %0h",
               $time, name, reg_rdata, expected);
    end
  endtask

  // Back-to-back random issues with idle gaps
  task automatic random_test();
    int          issued;
    logic        prev_issue;
    logic [11:0] held;
    logic [11:0] next_expect;
    logic [31:0] r;
    issued     = 0;
    prev_issue = 1'b0;
    held       = {corner_rows[NUM_ROWS-1].exp_error, corner_rows[NUM_ROWS-1].exp_result};
    next_expect = held;
    while (issued < NUM_RANDOM || prev_issue) begin
      @(negedge clk);
      checks++;
      if (result_valid !== prev_issue) begin
        errors++;
        $display("error at %0t: result_valid is %b, expected %b", $time, result_valid,
                 prev_issue);
      end
      if (prev_issue) held = next_expect;  // Otherwise outputs must hold
      if ({error_code, result} !== held) begin
        errors++;
        $display("error at %0t: random op gave %0d code %0d, expected %0d code %0d",
                 $time, result, error_code, held[7:0], held[11:8]);
      end
      r = $random(seed);
      if (issued < NUM_RANDOM && r[1:0] != 2'b00) begin
        issue       = 1'b1;
        operation   = operation_t'(r[4:2]);
        data_a      = r[15:8];
        data_b      = r[23:16];
        next_expect = expected_outcome(r[4:2], r[15:8], r[23:16], `ALU_OP_ENABLE_RESET,
                                       `ALU_SQRT_LIMIT_RESET);
        prev_issue  = 1'b1;
        issued++;
      end else begin
        issue      = 1'b0;
        prev_issue = 1'b0;
      end
    end
  endtask

  initial begin
    seed        = 32'hf018_8cb9;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    model_flags = 8'h00;
    model_count = 0;
    reset_n     = 1'b0;
    issue       = 1'b0;
    operation   = OP_ADD;
    data_a      = 8'd0;
    data_b      = 8'd0;
    reg_write   = 1'b0;
    reg_addr    = 2'd0;
    reg_wdata   = 8'd0;
    load_corner_rows();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    start_test();
    checks++;
    if (result_valid !== 1'b0 || result !== 8'd0 || error_code !== ERR_NONE) begin
      errors++;
      $display("error at %0t: core outputs not at reset values", $time);
    end
    check_reg(`ALU_REG_OP_ENABLE, 8'h3F, "OP_ENABLE");
    check_reg(`ALU_REG_SQRT_LIMIT, 8'd225, "SQRT_LIMIT");
    check_reg(`ALU_REG_ERR_FLAGS, 8'h00, "ERR_FLAGS");
    check_reg(`ALU_REG_ERR_COUNT, 8'h00, "ERR_COUNT");
    report_test("reset values");

    start_test();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_op(corner_rows[i].op, corner_rows[i].a, corner_rows[i].b,
             corner_rows[i].exp_result, corner_rows[i].exp_error);
    end
    report_test("corner cases");

    start_test();
    random_test();
    report_test("random operands");

    start_test();
    write_reg(`ALU_REG_OP_ENABLE, 8'h3B);  // MUL disabled
    check_reg(`ALU_REG_OP_ENABLE, 8'h3B, "OP_ENABLE");
    run_op(OP_MUL, 8'd3, 8'd4, 8'd0, ERR_INVALID_OP);
    run_op(OP_ADD, 8'd2, 8'd3, 8'd5, ERR_NONE);
    write_reg(`ALU_REG_OP_ENABLE, 8'h3F);
    run_op(OP_MUL, 8'd3, 8'd4, 8'd12, ERR_NONE);
    report_test("operation masking");

    start_test();
    write_reg(`ALU_REG_SQRT_LIMIT, 8'd100);
    check_reg(`ALU_REG_SQRT_LIMIT, 8'd100, "SQRT_LIMIT");
    run_op(OP_SQRT, 8'd100, 8'd0, 8'd10, ERR_NONE);
    run_op(OP_SQRT, 8'd101, 8'd0, 8'd0, ERR_OUT_OF_RANGE);
    write_reg(`ALU_REG_SQRT_LIMIT, 8'd225);
    report_test("sqrt limit");

    start_test();
    write_reg(`ALU_REG_ERR_FLAGS, 8'h3E);
    write_reg(`ALU_REG_ERR_COUNT, 8'h00);
    model_flags = 8'h00;
    model_count = 0;
    check_reg(`ALU_REG_ERR_FLAGS, 8'h00, "ERR_FLAGS");
    check_reg(`ALU_REG_ERR_COUNT, 8'h00, "ERR_COUNT");
    run_op(OP_ADD, 8'd1, 8'd1, 8'd2, ERR_NONE);
    run_op(OP_SUB, 8'd3, 8'd5, 8'd0, ERR_UNDERFLOW);
    run_op(OP_DIV, 8'd9, 8'd0, 8'd0, ERR_DIVIDE_ZERO);
    run_op(OP_MUL, 8'd20, 8'd20, 8'd255, ERR_OVERFLOW);
    run_op(3'd7, 8'd1, 8'd1, 8'd0, ERR_INVALID_OP);
    run_op(OP_SQRT, 8'd250, 8'd0, 8'd0, ERR_OUT_OF_RANGE);
    run_op(OP_MOD, 8'd5, 8'd0, 8'd0, ERR_DIVIDE_ZERO);
    check_reg(`ALU_REG_ERR_FLAGS, model_flags, "ERR_FLAGS");
    check_reg(`ALU_REG_ERR_COUNT, 8'(model_count), "ERR_COUNT");
    for (int i = 0; i < NUM_SAT; i++) begin
      run_op(OP_DIV, 8'(i), 8'd0, 8'd0, ERR_DIVIDE_ZERO);
    end
    check_reg(`ALU_REG_ERR_COUNT, 8'(model_count), "ERR_COUNT");
    write_reg(`ALU_REG_ERR_FLAGS, 8'h0C);  // Clear OVERFLOW and UNDERFLOW
    model_flags = model_flags & ~8'h0C;
    check_reg(`ALU_REG_ERR_FLAGS, model_flags, "ERR_FLAGS");
    write_reg(`ALU_REG_ERR_COUNT, 8'h5A);
    check_reg(`ALU_REG_ERR_COUNT, 8'h00, "ERR_COUNT");
    report_test("error recording");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/alu_config.svh
// ALU configuration constants
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath
`define ALU_DATA_W            8
`define ALU_NUM_OPS           6

// Host register port
`define ALU_REG_ADDR_W        2
`define ALU_REG_OP_ENABLE     2'd0
`define ALU_REG_SQRT_LIMIT    2'd1
`define ALU_REG_ERR_FLAGS     2'd2
`define ALU_REG_ERR_COUNT     2'd3

// Register reset values
`define ALU_OP_ENABLE_RESET   6'b11_1111
`define ALU_SQRT_LIMIT_RESET  8'd225

`endif

// File: verilog/alu_core.sv
// Checked arithmetic core
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_core import alu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      issue,
  input  operation_t                operation,
  input  logic [`ALU_DATA_W-1:0]    data_a,
  input  logic [`ALU_DATA_W-1:0]    data_b,
  input  logic [`ALU_NUM_OPS-1:0]   op_enable,
  input  logic [`ALU_DATA_W-1:0]    sqrt_limit,
  output logic [`ALU_DATA_W-1:0]    result,
  output error_code_t               error_code,
  output logic                      result_valid
);

  logic [`ALU_DATA_W:0]      sum;          // Carry in top bit
  logic [2*`ALU_DATA_W-1:0]  product;
  logic [7:0]                enable_ext;   // Codes 6 and 7 read as disabled
  logic                      op_allowed;
  logic [3:0]                sqrt_root;
  logic [`ALU_DATA_W-1:0]    next_result;
  error_code_t               next_error;

  assign sum     = {1'b0, data_a} + {1'b0, data_b};
  assign product = {{`ALU_DATA_W{1'b0}}, data_a} * {{`ALU_DATA_W{1'b0}}, data_b};

  assign enable_ext = 8'(op_enable);
  assign op_allowed = enable_ext[operation];

  isqrt_unit sqrt_unit (
    .radicand (data_a),
    .root     (sqrt_root)
  );

  // Result and error decision for the operation on the inputs
  always_comb begin
    next_result = '0;
    next_error  = ERR_NONE;

    if (!op_allowed) begin
      next_error = ERR_INVALID_OP;     // Masked or undefined code
    end else begin
      case (operation)
        OP_ADD: begin
          if (sum[`ALU_DATA_W]) begin
            next_result = '1;          // Saturate high
            next_error  = ERR_OVERFLOW;
          end else begin
            next_result = sum[`ALU_DATA_W-1:0];
          end
        end

        OP_SUB: begin
          if (data_a < data_b) begin
            next_error = ERR_UNDERFLOW;  // Result stays at 0
          end else begin
            next_result = data_a - data_b;
          end
        end

        OP_MUL: begin
          if (|product[2*`ALU_DATA_W-1:`ALU_DATA_W]) begin
            next_result = '1;
            next_error  = ERR_OVERFLOW;
          end else begin
            next_result = product[`ALU_DATA_W-1:0];
          end
        end

        OP_DIV: begin
          if (data_b == '0) begin
            next_error = ERR_DIVIDE_ZERO;
          end else begin
            next_result = data_a / data_b;
          end
        end

        OP_MOD: begin
          if (data_b == '0) begin
            next_error = ERR_DIVIDE_ZERO;
          end else begin
            next_result = data_a % data_b;
          end
        end

        OP_SQRT: begin
          if (data_a > sqrt_limit) begin
            next_error = ERR_OUT_OF_RANGE;  // Host-programmed limit
          end else begin
            next_result = {4'b0000, sqrt_root};
          end
        end

        default: begin
          next_error = ERR_INVALID_OP;
        end
      endcase
    end
  end

  // Outputs update only on issue and hold in between
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result       <= '0;
      error_code   <= ERR_NONE;
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue;           // One-cycle pulse per issue
      if (issue) begin
        result     <= next_result;
        error_code <= next_error;
      end
    end
  end

endmodule

// File: verilog/alu_pkg.sv
// ALU operation and error types
package alu_pkg;

  // Error codes reported with every result
  typedef enum logic [3:0] {
    ERR_NONE         = 4'h0,  // Clean result
    ERR_DIVIDE_ZERO  = 4'h1,  // Zero divisor on div or mod
    ERR_OVERFLOW     = 4'h2,  // Add or mul saturated high
    ERR_UNDERFLOW    = 4'h3,  // Sub saturated low
    ERR_INVALID_OP   = 4'h4,  // Undefined or masked operation
    ERR_OUT_OF_RANGE = 4'h5,  // Sqrt input above limit
    ERR_TIMEOUT      = 4'h6,  // Reserved, never raised
    ERR_UNKNOWN      = 4'hF   // Reserved, never raised
  } error_code_t;

  // Operation select, codes 6 and 7 are undefined
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_MUL  = 3'd2,
    OP_DIV  = 3'd3,
    OP_MOD  = 3'd4,
    OP_SQRT = 3'd5
  } operation_t;

endpackage

// File: verilog/alu_subsystem.sv
// Checked ALU subsystem top
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_subsystem import alu_pkg::*; (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        issue,
  input  operation_t                  operation,
  input  logic [`ALU_DATA_W-1:0]      data_a,
  input  logic [`ALU_DATA_W-1:0]      data_b,
  output logic [`ALU_DATA_W-1:0]      result,
  output error_code_t                 error_code,
  output logic                        result_valid,
  input  logic                        reg_write,
  input  logic [`ALU_REG_ADDR_W-1:0]  reg_addr,
  input  logic [`ALU_DATA_W-1:0]      reg_wdata,
  output logic [`ALU_DATA_W-1:0]      reg_rdata
);

  logic [`ALU_NUM_OPS-1:0]  op_enable;   // Mask from register block
  logic [`ALU_DATA_W-1:0]   sqrt_limit;

  alu_core core (
    .clk          (clk),
    .reset_n      (reset_n),
    .issue        (issue),
    .operation    (operation),
    .data_a       (data_a),
    .data_b       (data_b),
    .op_enable    (op_enable),
    .sqrt_limit   (sqrt_limit),
    .result       (result),
    .error_code   (error_code),
    .result_valid (result_valid)
  );

  // Records what the core reports and steers it back
  error_status_regs status_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .reg_write    (reg_write),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .result_valid (result_valid),
    .error_code   (error_code),
    .op_enable    (op_enable),
    .sqrt_limit   (sqrt_limit)
  );

endmodule

// File: verilog/error_status_regs.sv
// Error status register block
`timescale 1ns/1ps
`include "alu_config.svh"

module error_status_regs import alu_pkg::*; (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        reg_write,
  input  logic [`ALU_REG_ADDR_W-1:0]  reg_addr,
  input  logic [`ALU_DATA_W-1:0]      reg_wdata,
  output logic [`ALU_DATA_W-1:0]      reg_rdata,
  input  logic                        result_valid,
  input  error_code_t                 error_code,
  output logic [`ALU_NUM_OPS-1:0]     op_enable,
  output logic [`ALU_DATA_W-1:0]      sqrt_limit
);

  logic [5:1]               err_flags;    // Bit n holds code n
  logic [`ALU_DATA_W-1:0]   err_count;
  logic [5:1]               flag_set;
  logic [5:1]               flag_clr;
  logic                     err_event;
  logic                     wr_op_enable;
  logic                     wr_sqrt_limit;
  logic                     wr_err_flags;
  logic                     wr_err_count;

  // Write strobes per register
  assign wr_op_enable  = reg_write && (reg_addr == `ALU_REG_OP_ENABLE);
  assign wr_sqrt_limit = reg_write && (reg_addr == `ALU_REG_SQRT_LIMIT);
  assign wr_err_flags  = reg_write && (reg_addr == `ALU_REG_ERR_FLAGS);
  assign wr_err_count  = reg_write && (reg_addr == `ALU_REG_ERR_COUNT);

  assign err_event = result_valid && (error_code != ERR_NONE);

  // One-hot flag for codes 1 to 5 only
  always_comb begin
    for (int n = 1; n <= 5; n++) begin
      flag_set[n] = result_valid && (error_code == error_code_t'(n));
    end
  end

  assign flag_clr = wr_err_flags ? reg_wdata[5:1] : '0;  // Write one to clear

  // Control registers steering the core
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      op_enable  <= `ALU_OP_ENABLE_RESET;
      sqrt_limit <= `ALU_SQRT_LIMIT_RESET;
    end else begin
      if (wr_op_enable) begin
        op_enable <= reg_wdata[`ALU_NUM_OPS-1:0];
      end
      if (wr_sqrt_limit) begin
        sqrt_limit <= reg_wdata;
      end
    end
  end

  // Sticky flags where a new error beats a clear of the same bit
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      err_flags <= '0;
    end else begin
      err_flags <= (err_flags & ~flag_clr) | flag_set;
    end
  end

  // Error counter stops at all ones
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      err_count <= '0;
    end else if (wr_err_count) begin
      err_count <= '0;                 // Any write clears
    end else if (err_event && (err_count != '1)) begin
      err_count <= err_count + `ALU_DATA_W'(1);
    end
  end

  // Combinational read mux
  always_comb begin
    case (reg_addr)
      `ALU_REG_OP_ENABLE:  reg_rdata = 8'(op_enable);
      `ALU_REG_SQRT_LIMIT: reg_rdata = sqrt_limit;
      `ALU_REG_ERR_FLAGS:  reg_rdata = {2'b00, err_flags, 1'b0};
      default:             reg_rdata = err_count;
    endcase
  end

endmodule

// File: verilog/isqrt_unit.sv
// Floor square root unit
`timescale 1ns/1ps

module isqrt_unit (
  input  logic [7:0] radicand,
  output logic [3:0] root
);

  // Partial remainder never exceeds 2*root, so 5 bits hold it between steps
  logic [4:0] rem_s  [0:3];
  logic [3:0] root_s [0:4];

  assign rem_s[0]  = '0;
  assign root_s[0] = '0;

  // One restoring step per radicand bit pair, MSB pair first
  for (genvar i = 0; i < 4; i++) begin : g_step
    logic [6:0] shifted;
    logic [6:0] trial;

    assign shifted = {rem_s[i], radicand[7-2*i -: 2]};     // Bring down next pair
    assign trial   = shifted - {1'b0, root_s[i], 2'b01};    // Subtract 4q+1
    assign root_s[i+1] = {root_s[i][2:0], ~trial[6]};       // Digit is 1 if no borrow

    if (i < 3) begin : g_rem
      // Restore on borrow, keep the difference otherwise
      assign rem_s[i+1] = trial[6] ? shifted[4:0] : trial[4:0];
    end
  end

  assign root = root_s[4];

endmodule
